/* hdl/isa_pkg.sv */
package isa_pkg;

    localparam int INSN_WIDTH    = 24;
    localparam int OPC_WIDTH     = 4;
    localparam int REG_SEL_WIDTH = 3;
    localparam int IMM_WIDTH     = 8;

    // lsb of each field with the opcode on top
    localparam int OPC_LSB  = 20;
    localparam int DST_LSB  = 17;
    localparam int SRC0_LSB = 14;
    localparam int SRC1_LSB = 11;
    localparam int SRC2_LSB = 8;
    localparam int IMM_LSB  = 0;

    typedef enum logic [OPC_WIDTH-1:0] {
        NOP,
        READY,
        ADD,
        SUB,
        MUL,
        CMPGE,
        RSHIFT,
        LSHIFT,
        AND,
        OR,
        XOR,
        LD,
        SET_CONST,
        ST,
        BNZ
    } opcode_t;

    localparam logic [INSN_WIDTH-1:0] NOP_INSN   = '0;
    localparam logic [INSN_WIDTH-1:0] READY_INSN = {READY, {(INSN_WIDTH - OPC_WIDTH){1'b0}}};

    function automatic opcode_t insn_opcode(input logic [INSN_WIDTH-1:0] insn);
        return opcode_t'(insn[OPC_LSB +: OPC_WIDTH]);
    endfunction

    function automatic logic [REG_SEL_WIDTH-1:0] insn_reg(input logic [INSN_WIDTH-1:0] insn,
                                                          input int lsb);
        return insn[lsb +: REG_SEL_WIDTH];
    endfunction

    function automatic logic [IMM_WIDTH-1:0] insn_imm(input logic [INSN_WIDTH-1:0] insn);
        return insn[IMM_LSB +: IMM_WIDTH];
    endfunction

    function automatic logic is_alu_op(input opcode_t op);
        return op inside {ADD, SUB, MUL, CMPGE, RSHIFT, LSHIFT, AND, OR, XOR};
    endfunction

    function automatic logic is_writer(input opcode_t op);
        return is_alu_op(op) || op == LD || op == SET_CONST;
    endfunction

    function automatic logic reads_src0(input opcode_t op);
        return is_alu_op(op) || op inside {LD, ST, BNZ};
    endfunction

    function automatic logic reads_src1(input opcode_t op);
        return is_alu_op(op) || op == ST;
    endfunction

    // no opcode reads the third source field yet
    function automatic logic reads_src2(input opcode_t op);
        return 1'b0;
    endfunction

endpackage

/* hdl/mem_pkg.sv */
package mem_pkg;

    localparam int DATA_WIDTH = 16;   // register and memory word
    localparam int ADDR_WIDTH = 8;

    typedef enum logic [1:0] {
        ACC_NONE,
        ACC_LOAD,
        ACC_STORE
    } access_t;

endpackage

/* hdl/register_file.sv */
`timescale 1ns/1ns

module register_file (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [isa_pkg::REG_SEL_WIDTH-1:0]  rd_sel0,
    input  logic [isa_pkg::REG_SEL_WIDTH-1:0]  rd_sel1,
    input  logic [isa_pkg::REG_SEL_WIDTH-1:0]  rd_sel2,
    output logic [mem_pkg::DATA_WIDTH-1:0]     rd_data0,
    output logic [mem_pkg::DATA_WIDTH-1:0]     rd_data1,
    output logic [mem_pkg::DATA_WIDTH-1:0]     rd_data2,
    input  logic                               wr_en,
    input  logic [isa_pkg::REG_SEL_WIDTH-1:0]  wr_sel,
    input  logic [mem_pkg::DATA_WIDTH-1:0]     wr_data,
    input  logic                               preset_en,
    input  logic [mem_pkg::DATA_WIDTH-1:0]     preset_data
);
    localparam int NUM_REGS = 2 ** isa_pkg::REG_SEL_WIDTH;

    logic [mem_pkg::DATA_WIDTH-1:0] regs [NUM_REGS];

    // write-through so decode sees the value written back this cycle
    function automatic logic [mem_pkg::DATA_WIDTH-1:0] read_port(
        input logic [isa_pkg::REG_SEL_WIDTH-1:0] sel);
        if (wr_en && wr_sel == sel)
            return wr_data;
        return regs[sel];
    endfunction

    always_comb
    begin
        rd_data0 = read_port(rd_sel0);
        rd_data1 = read_port(rd_sel1);
        rd_data2 = read_port(rd_sel2);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (preset_en)
            regs[0] <= preset_data;   // host preset wins
        else if (wr_en)
            regs[wr_sel] <= wr_data;
    end

endmodule

/* hdl/insn_memory.sv */
`timescale 1ns/1ns

module insn_memory #(
    parameter int INSN_DEPTH = 64
) (
    input  logic                              clk,
    input  logic                              wr_en,
    input  logic [$clog2(INSN_DEPTH)-1:0]     wr_addr,
    input  logic [isa_pkg::INSN_WIDTH-1:0]    wr_data,
    input  logic [$clog2(INSN_DEPTH)-1:0]     pc,
    output logic [isa_pkg::INSN_WIDTH-1:0]    insn
);
    logic [isa_pkg::INSN_WIDTH-1:0] mem [INSN_DEPTH];

    // slots never written by the host fetch as NOP
    initial
    begin
        for (int i = 0; i < INSN_DEPTH; i++)
            mem[i] = isa_pkg::NOP_INSN;
    end

    always @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    assign insn = mem[pc];   // async fetch

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ns

module alu (
    input  isa_pkg::opcode_t                opcode,
    input  logic [mem_pkg::DATA_WIDTH-1:0]  a,
    input  logic [mem_pkg::DATA_WIDTH-1:0]  b,
    output logic [mem_pkg::DATA_WIDTH-1:0]  result,
    output logic                            branch_taken
);
    logic [3:0] shamt;

    assign shamt = b[3:0];

    always_comb
    begin
        case (opcode)
            isa_pkg::ADD:    result = a + b;
            isa_pkg::SUB:    result = a - b;
            isa_pkg::MUL:    result = a * b;   // low half only
            isa_pkg::CMPGE:  result = {{(mem_pkg::DATA_WIDTH - 1){1'b0}}, a >= b};
            isa_pkg::RSHIFT: result = a >> shamt;
            isa_pkg::LSHIFT: result = a << shamt;
            isa_pkg::AND:    result = a & b;
            isa_pkg::OR:     result = a | b;
            isa_pkg::XOR:    result = a ^ b;
            default:         result = '0;
        endcase
    end

    assign branch_taken = (opcode == isa_pkg::BNZ) && (a != '0);

endmodule

/* hdl/pipeline_core.sv */
`timescale 1ns/1ns

module pipeline_core #(
    parameter int INSN_DEPTH = 64
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              start,
    input  logic                              init_r0,
    input  logic [mem_pkg::DATA_WIDTH-1:0]    init_r0_data,
    output logic                              ready,
    input  logic                              prog_we,
    input  logic [$clog2(INSN_DEPTH)-1:0]     prog_addr,
    input  logic [isa_pkg::INSN_WIDTH-1:0]    prog_data,
    output mem_pkg::access_t                  mem_en,
    output logic [mem_pkg::ADDR_WIDTH-1:0]    mem_addr,
    output logic [mem_pkg::DATA_WIDTH-1:0]    mem_wdata,
    input  logic                              mem_ready,
    input  logic [mem_pkg::DATA_WIDTH-1:0]    mem_rdata
);
    localparam int PC_WIDTH = $clog2(INSN_DEPTH);
    localparam int DW = mem_pkg::DATA_WIDTH;
    localparam int RS = isa_pkg::REG_SEL_WIDTH;
    localparam int IW = isa_pkg::INSN_WIDTH;

    logic [PC_WIDTH-1:0] pc;
    logic [IW-1:0] mem_word, fetched;
    logic [IW-1:0] fd_insn, dx_insn, xm_insn, mw_insn;
    logic [DW-1:0] rd_data0, rd_data1, dx_a, dx_b;
    logic [DW-1:0] fwd_a, fwd_b, alu_result, x_result;
    logic [DW-1:0] xm_result, xm_wdata, m_result, mw_result;
    logic launch, mem_wait, freeze, load_use, stall, branch_taken;
    logic xm_fwd, mw_fwd;

    isa_pkg::opcode_t fd_op, dx_op, xm_op, mw_op;
    logic [RS-1:0] fd_src0, fd_src1, fd_src2;
    logic [RS-1:0] dx_dst, dx_src0, dx_src1, xm_dst, xm_src1, mw_dst;
    logic [isa_pkg::IMM_WIDTH-1:0] dx_imm;

    assign fd_op   = isa_pkg::insn_opcode(fd_insn);
    assign fd_src0 = isa_pkg::insn_reg(fd_insn, isa_pkg::SRC0_LSB);
    assign fd_src1 = isa_pkg::insn_reg(fd_insn, isa_pkg::SRC1_LSB);
    assign fd_src2 = isa_pkg::insn_reg(fd_insn, isa_pkg::SRC2_LSB);
    assign dx_op   = isa_pkg::insn_opcode(dx_insn);
    assign dx_dst  = isa_pkg::insn_reg(dx_insn, isa_pkg::DST_LSB);
    assign dx_src0 = isa_pkg::insn_reg(dx_insn, isa_pkg::SRC0_LSB);
    assign dx_src1 = isa_pkg::insn_reg(dx_insn, isa_pkg::SRC1_LSB);
    assign dx_imm  = isa_pkg::insn_imm(dx_insn);
    assign xm_op   = isa_pkg::insn_opcode(xm_insn);
    assign xm_dst  = isa_pkg::insn_reg(xm_insn, isa_pkg::DST_LSB);
    assign xm_src1 = isa_pkg::insn_reg(xm_insn, isa_pkg::SRC1_LSB);
    assign mw_op   = isa_pkg::insn_opcode(mw_insn);
    assign mw_dst  = isa_pkg::insn_reg(mw_insn, isa_pkg::DST_LSB);

    insn_memory #(.INSN_DEPTH(INSN_DEPTH)) insn_mem0 (
        .clk(clk),
        .wr_en(prog_we && ready), .wr_addr(prog_addr), .wr_data(prog_data),
        .pc(pc), .insn(mem_word)
    );

    // last slot always ends the program
    assign fetched = (pc == PC_WIDTH'(INSN_DEPTH - 1)) ? isa_pkg::READY_INSN : mem_word;

    register_file regs0 (
        .clk(clk), .reset(reset),
        .rd_sel0(fd_src0), .rd_sel1(fd_src1), .rd_sel2(fd_src2),
        .rd_data0(rd_data0), .rd_data1(rd_data1), .rd_data2(),
        .wr_en(isa_pkg::is_writer(mw_op)), .wr_sel(mw_dst), .wr_data(mw_result),
        .preset_en(launch && init_r0), .preset_data(init_r0_data)
    );

    assign launch   = start && ready;
    assign mem_wait = (xm_op == isa_pkg::LD || xm_op == isa_pkg::ST) && !mem_ready;
    assign freeze   = ready || mem_wait;

    // store data from a load is patched in the memory stage, so no bubble for it
    assign load_use = (dx_op == isa_pkg::LD)
        && ((isa_pkg::reads_src0(fd_op) && fd_src0 == dx_dst)
         || (isa_pkg::reads_src1(fd_op) && fd_op != isa_pkg::ST && fd_src1 == dx_dst)
         || (isa_pkg::reads_src2(fd_op) && fd_src2 == dx_dst));
    assign stall = load_use || dx_op == isa_pkg::READY;   // nothing passes a READY

    assign xm_fwd = isa_pkg::is_writer(xm_op) && xm_op != isa_pkg::LD;
    assign mw_fwd = isa_pkg::is_writer(mw_op);

    function automatic logic [DW-1:0] forward(input logic [RS-1:0] sel,
                                              input logic [DW-1:0] reg_val);
        if (xm_fwd && xm_dst == sel)
            return xm_result;   // youngest first
        if (mw_fwd && mw_dst == sel)
            return mw_result;
        return reg_val;
    endfunction

    always_comb
    begin
        fwd_a = forward(dx_src0, dx_a);
        fwd_b = forward(dx_src1, dx_b);
    end

    alu alu0 (
        .opcode(dx_op), .a(fwd_a), .b(fwd_b),
        .result(alu_result), .branch_taken(branch_taken)
    );

    always_comb
    begin
        case (dx_op)
            isa_pkg::SET_CONST:       x_result = DW'(dx_imm);
            isa_pkg::LD, isa_pkg::ST: x_result = fwd_a;   // address
            default:                  x_result = alu_result;
        endcase
    end

    assign mem_en = (xm_op == isa_pkg::LD) ? mem_pkg::ACC_LOAD :
                    (xm_op == isa_pkg::ST) ? mem_pkg::ACC_STORE : mem_pkg::ACC_NONE;
    assign mem_addr = xm_result[mem_pkg::ADDR_WIDTH-1:0];
    assign mem_wdata = (mw_op == isa_pkg::LD && xm_op == isa_pkg::ST && mw_dst == xm_src1)
                     ? mw_result : xm_wdata;
    assign m_result = (xm_op == isa_pkg::LD) ? mem_rdata : xm_result;

    always_ff @(posedge clk)
    begin
        if (reset)
            ready <= 1'b1;
        else if (launch)
            ready <= 1'b0;
        else if (xm_op == isa_pkg::READY)
            ready <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (reset || launch)
        begin
            pc <= '0;
            fd_insn <= isa_pkg::NOP_INSN;
            dx_insn <= isa_pkg::NOP_INSN;
            xm_insn <= isa_pkg::NOP_INSN;
            mw_insn <= isa_pkg::NOP_INSN;
        end
        else if (!freeze)
        begin
            if (branch_taken)
            begin
                pc <= PC_WIDTH'(dx_imm);
                fd_insn <= isa_pkg::NOP_INSN;   // flush
            end
            else if (!stall)
            begin
                pc <= pc + 1'b1;
                fd_insn <= fetched;
            end
            dx_insn <= (branch_taken || stall) ? isa_pkg::NOP_INSN : fd_insn;
            xm_insn <= dx_insn;
            mw_insn <= xm_insn;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!freeze)
        begin
            dx_a <= rd_data0;
            dx_b <= rd_data1;
            xm_result <= x_result;
            xm_wdata <= fwd_b;
            mw_result <= m_result;
        end
    end

endmodule

/* hdl/data_memory.sv */
`timescale 1ns/1ns

module data_memory #(
    parameter int DATA_DEPTH = 256,
    parameter int MAX_WAIT   = 3
) (
    input  logic                              clk,
    input  logic                              reset,
    input  mem_pkg::access_t                  en,
    input  logic [mem_pkg::ADDR_WIDTH-1:0]    addr,
    input  logic [mem_pkg::DATA_WIDTH-1:0]    wdata,
    output logic                              ready,
    output logic [mem_pkg::DATA_WIDTH-1:0]    rdata,
    input  logic [mem_pkg::ADDR_WIDTH-1:0]    dbg_addr,
    output logic [mem_pkg::DATA_WIDTH-1:0]    dbg_data
);
    logic [mem_pkg::DATA_WIDTH-1:0] ram [DATA_DEPTH];
    logic [7:0] lfsr;
    logic [7:0] wait_cnt;
    logic busy;   // one access in flight

    assign ready    = busy && wait_cnt == '0;
    assign rdata    = ram[addr];
    assign dbg_data = ram[dbg_addr];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lfsr <= 8'hb5;
            busy <= 1'b0;
            wait_cnt <= '0;
        end
        else
        begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            if (en != mem_pkg::ACC_NONE && !busy)
            begin
                busy <= 1'b1;
                wait_cnt <= lfsr % 8'(MAX_WAIT + 1);   // 0..MAX_WAIT
            end
            else if (ready)
                busy <= 1'b0;
            else if (busy)
                wait_cnt <= wait_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < DATA_DEPTH; i++)
                ram[i] <= '0;
        end
        else if (ready && en == mem_pkg::ACC_STORE)
            ram[addr] <= wdata;
    end

endmodule

/* hdl/core_system.sv */
`timescale 1ns/1ns

module core_system #(
    parameter int INSN_DEPTH = 64,
    parameter int DATA_DEPTH = 256,
    parameter int MAX_WAIT   = 3
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              prog_we,
    input  logic [$clog2(INSN_DEPTH)-1:0]     prog_addr,
    input  logic [isa_pkg::INSN_WIDTH-1:0]    prog_data,
    input  logic                              init_r0,
    input  logic [mem_pkg::DATA_WIDTH-1:0]    init_r0_data,
    input  logic                              start,
    output logic                              ready,
    input  logic [mem_pkg::ADDR_WIDTH-1:0]    dbg_addr,
    output logic [mem_pkg::DATA_WIDTH-1:0]    dbg_data
);
    mem_pkg::access_t                mem_en;
    logic [mem_pkg::ADDR_WIDTH-1:0]  mem_addr;
    logic [mem_pkg::DATA_WIDTH-1:0]  mem_wdata;
    logic [mem_pkg::DATA_WIDTH-1:0]  mem_rdata;
    logic                            mem_ready;

    pipeline_core #(.INSN_DEPTH(INSN_DEPTH)) core0 (
        .clk(clk), .reset(reset),
        .start(start), .init_r0(init_r0), .init_r0_data(init_r0_data), .ready(ready),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .mem_en(mem_en), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_ready(mem_ready), .mem_rdata(mem_rdata)
    );

    data_memory #(.DATA_DEPTH(DATA_DEPTH), .MAX_WAIT(MAX_WAIT)) dmem0 (
        .clk(clk), .reset(reset),
        .en(mem_en), .addr(mem_addr), .wdata(mem_wdata),
        .ready(mem_ready), .rdata(mem_rdata),
        .dbg_addr(dbg_addr), .dbg_data(dbg_data)
    );

endmodule

/* dv/result_checker.sv */
`timescale 1ns/1ns

module result_checker #(
    parameter int INSN_DEPTH = 64,
    parameter int DATA_DEPTH = 256
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              prog_we,
    input  logic [$clog2(INSN_DEPTH)-1:0]     prog_addr,
    input  logic [isa_pkg::INSN_WIDTH-1:0]    prog_data,
    input  logic                              start,
    input  logic                              init_r0,
    input  logic [mem_pkg::DATA_WIDTH-1:0]    init_r0_data,
    input  logic                              ready,
    output logic [mem_pkg::ADDR_WIDTH-1:0]    dbg_addr,
    input  logic [mem_pkg::DATA_WIDTH-1:0]    dbg_data,
    output int                                checked_count,
    output int                                error_count
);
    localparam int DW = mem_pkg::DATA_WIDTH;
    localparam int STEP_LIMIT = 1000;

    logic [isa_pkg::INSN_WIDTH-1:0] prog_copy [INSN_DEPTH];
    logic [DW-1:0] ref_regs [8];   // persist across runs like the DUT's
    logic [DW-1:0] ref_mem [DATA_DEPTH];
    logic running;

    // instruction-level model that returns the executed count or -1 without a READY
    function automatic int interpret();
        int pc;
        int steps;
        int result;
        int dst;
        logic [isa_pkg::INSN_WIDTH-1:0] w;
        isa_pkg::opcode_t op;
        logic [DW-1:0] a;
        logic [DW-1:0] b;
        logic [isa_pkg::IMM_WIDTH-1:0] imm;
        pc = 0;
        steps = 0;
        result = -1;
        while (result < 0 && steps < STEP_LIMIT)
        begin
            w = prog_copy[pc];
            if (pc == INSN_DEPTH - 1)
            begin
                w = '0;
                w[isa_pkg::OPC_LSB +: isa_pkg::OPC_WIDTH] = isa_pkg::READY;
            end
            op = isa_pkg::opcode_t'(w[isa_pkg::OPC_LSB +: isa_pkg::OPC_WIDTH]);
            dst = w[isa_pkg::DST_LSB +: isa_pkg::REG_SEL_WIDTH];
            a = ref_regs[w[isa_pkg::SRC0_LSB +: isa_pkg::REG_SEL_WIDTH]];
            b = ref_regs[w[isa_pkg::SRC1_LSB +: isa_pkg::REG_SEL_WIDTH]];
            imm = w[isa_pkg::IMM_LSB +: isa_pkg::IMM_WIDTH];
            steps++;
            pc = pc + 1;
            case (op)
                isa_pkg::READY:     result = steps;
                isa_pkg::ADD:       ref_regs[dst] = a + b;
                isa_pkg::SUB:       ref_regs[dst] = a - b;
                isa_pkg::MUL:       ref_regs[dst] = a * b;
                isa_pkg::CMPGE:     ref_regs[dst] = (a >= b) ? 1 : 0;
                isa_pkg::RSHIFT:    ref_regs[dst] = a >> b[3:0];
                isa_pkg::LSHIFT:    ref_regs[dst] = a << b[3:0];
                isa_pkg::AND:       ref_regs[dst] = a & b;
                isa_pkg::OR:        ref_regs[dst] = a | b;
                isa_pkg::XOR:       ref_regs[dst] = a ^ b;
                isa_pkg::SET_CONST: ref_regs[dst] = DW'(imm);
                isa_pkg::LD:        ref_regs[dst] = ref_mem[a[mem_pkg::ADDR_WIDTH-1:0]];
                isa_pkg::ST:        ref_mem[a[mem_pkg::ADDR_WIDTH-1:0]] = b;
                isa_pkg::BNZ:
                begin
                    if (a != '0)
                        pc = imm % INSN_DEPTH;
                end
                default:            ;   // NOP
            endcase
        end
        return result;
    endfunction

    task automatic compare_memory(input int test_no, input int steps);
        int bad;
        bad = 0;
        dbg_addr <= '0;
        for (int addr = 0; addr < DATA_DEPTH; addr++)
        begin
            @(posedge clk);
            if (dbg_data !== ref_mem[addr])
            begin
                $display("MISMATCH at %0t: dbg_data addr 0x%02h expected 0x%04h actual 0x%04h",
                         $time, addr, ref_mem[addr], dbg_data);
                bad++;
            end
            dbg_addr <= mem_pkg::ADDR_WIDTH'(addr + 1);
        end
        error_count += bad;
        $display("test %0d: %0d instructions, %0d wrong words", test_no, steps, bad);
        checked_count++;
    endtask

    initial
    begin
        int steps;
        dbg_addr <= '0;
        checked_count = 0;
        error_count = 0;
        running = 1'b0;
        for (int i = 0; i < INSN_DEPTH; i++)
            prog_copy[i] = '0;
        for (int i = 0; i < 8; i++)
            ref_regs[i] = '0;
        for (int i = 0; i < DATA_DEPTH; i++)
            ref_mem[i] = '0;
        forever
        begin
            @(posedge clk);
            if (reset)
                running = 1'b0;
            else if (running && ready)
            begin
                running = 1'b0;
                steps = interpret();
                if (steps < 0)
                begin
                    $display("test %0d: reference program ran %0d steps without a READY",
                             checked_count + 1, STEP_LIMIT);
                    error_count++;
                end
                compare_memory(checked_count + 1, steps);
            end
            else if (start && ready)
            begin
                running = 1'b1;
                if (init_r0)
                    ref_regs[0] = init_r0_data;
            end
            else if (prog_we && ready)
                prog_copy[prog_addr] = prog_data;   // host writes only while idle
        end
    end

endmodule

/* dv/core_system_tb.sv */
`timescale 1ns/1ns

module core_system_tb;

    localparam int INSN_DEPTH = 64;
    localparam int DATA_DEPTH = 256;
    localparam int MAX_WAIT   = 3;
    localparam int PC_WIDTH   = $clog2(INSN_DEPTH);
    localparam int NUM_TESTS  = 5;
    localparam int MAX_INSNS  = 400;   // test 4 loop runs about 300
    localparam int TIMEOUT_CYCLES = NUM_TESTS * MAX_INSNS * (MAX_WAIT + 2) * 2;

    logic                              clk;
    logic                              reset;
    logic                              prog_we;
    logic [PC_WIDTH-1:0]               prog_addr;
    logic [isa_pkg::INSN_WIDTH-1:0]    prog_data;
    logic                              init_r0;
    logic [mem_pkg::DATA_WIDTH-1:0]    init_r0_data;
    logic                              start;
    logic                              ready;
    logic [mem_pkg::ADDR_WIDTH-1:0]    dbg_addr;
    logic [mem_pkg::DATA_WIDTH-1:0]    dbg_data;
    int                                checked_count;
    int                                error_count;
    int                                cycle_count;
    integer                            seed;
    logic [mem_pkg::DATA_WIDTH-1:0]    preset_value;
    logic [isa_pkg::INSN_WIDTH-1:0]    program_q [$];

    core_system #(
        .INSN_DEPTH(INSN_DEPTH), .DATA_DEPTH(DATA_DEPTH), .MAX_WAIT(MAX_WAIT)
    ) dut0 (
        .clk(clk), .reset(reset),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .init_r0(init_r0), .init_r0_data(init_r0_data),
        .start(start), .ready(ready),
        .dbg_addr(dbg_addr), .dbg_data(dbg_data)
    );

    result_checker #(.INSN_DEPTH(INSN_DEPTH), .DATA_DEPTH(DATA_DEPTH)) checker0 (
        .clk(clk), .reset(reset),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .start(start), .init_r0(init_r0), .init_r0_data(init_r0_data),
        .ready(ready), .dbg_addr(dbg_addr), .dbg_data(dbg_data),
        .checked_count(checked_count), .error_count(error_count)
    );

    always #20 clk = ~clk;

    function automatic void append_insn(input isa_pkg::opcode_t op, input int dst,
                                        input int src0, input int src1, input int imm);
        logic [isa_pkg::INSN_WIDTH-1:0] w;
        w = '0;
        w[isa_pkg::OPC_LSB +: isa_pkg::OPC_WIDTH] = op;
        w[isa_pkg::DST_LSB +: isa_pkg::REG_SEL_WIDTH] = isa_pkg::REG_SEL_WIDTH'(dst);
        w[isa_pkg::SRC0_LSB +: isa_pkg::REG_SEL_WIDTH] = isa_pkg::REG_SEL_WIDTH'(src0);
        w[isa_pkg::SRC1_LSB +: isa_pkg::REG_SEL_WIDTH] = isa_pkg::REG_SEL_WIDTH'(src1);
        w[isa_pkg::IMM_LSB +: isa_pkg::IMM_WIDTH] = isa_pkg::IMM_WIDTH'(imm);
        program_q.push_back(w);
    endfunction

    // straight-line code over every slot with READY replacing the last in fetch
    task automatic build_random_program();
        isa_pkg::opcode_t ops [13];
        int pick;
        ops = '{isa_pkg::ADD, isa_pkg::SUB, isa_pkg::MUL, isa_pkg::CMPGE, isa_pkg::RSHIFT,
                isa_pkg::LSHIFT, isa_pkg::AND, isa_pkg::OR, isa_pkg::XOR, isa_pkg::LD,
                isa_pkg::SET_CONST, isa_pkg::ST, isa_pkg::NOP};
        program_q.delete();
        append_insn(isa_pkg::ST, 0, 0, 0, 0);   // preset r0 lands at its own address
        for (int i = 1; i < INSN_DEPTH; i++)
        begin
            pick = $unsigned($random(seed)) % 13;
            append_insn(ops[pick], $random(seed), $random(seed), $random(seed), $random(seed));
        end
    endtask

    task automatic run_program(input logic preset, input logic [mem_pkg::DATA_WIDTH-1:0] value,
                               input int test_no);
        foreach (program_q[i])
        begin
            @(posedge clk);
            prog_we <= 1'b1;
            prog_addr <= PC_WIDTH'(i);
            prog_data <= program_q[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        start <= 1'b1;
        init_r0 <= preset;
        init_r0_data <= value;
        @(posedge clk);
        start <= 1'b0;
        init_r0 <= 1'b0;
        do
            @(posedge clk);
        while (!ready);
        while (checked_count < test_no)   // checker walks the whole memory first
            @(posedge clk);
    endtask

    initial
    begin
        clk = 1'b0;
        reset <= 1'b1;
        prog_we <= 1'b0;
        prog_addr <= '0;
        prog_data <= '0;
        init_r0 <= 1'b0;
        init_r0_data <= '0;
        start <= 1'b0;
        seed = 32'hd8c144ba;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // ALU functions with results from 0x10 upward
        program_q.delete();
        append_insn(isa_pkg::SET_CONST, 1, 0, 0, 8'hb7);
        append_insn(isa_pkg::SET_CONST, 2, 0, 0, 8'h05);
        append_insn(isa_pkg::MUL, 1, 1, 1, 0);   // wide operand
        append_insn(isa_pkg::SET_CONST, 6, 0, 0, 1);
        append_insn(isa_pkg::SET_CONST, 7, 0, 0, 8'h10);
        for (int op = isa_pkg::ADD; op <= isa_pkg::XOR; op++)
        begin
            append_insn(isa_pkg::opcode_t'(op), 3, 1, 2, 0);
            append_insn(isa_pkg::ST, 0, 7, 3, 0);
            append_insn(isa_pkg::ADD, 7, 7, 6, 0);
        end
        append_insn(isa_pkg::ST, 0, 7, 2, 0);
        append_insn(isa_pkg::READY, 0, 0, 0, 0);
        run_program(1'b0, '0, 1);

        // forwarding, load-use and load into store
        program_q.delete();
        append_insn(isa_pkg::SET_CONST, 1, 0, 0, 8'h20);
        append_insn(isa_pkg::ADD, 2, 1, 1, 0);
        append_insn(isa_pkg::SUB, 3, 2, 1, 0);
        append_insn(isa_pkg::MUL, 4, 3, 1, 0);
        append_insn(isa_pkg::ST, 0, 2, 4, 0);
        append_insn(isa_pkg::LD, 5, 2, 0, 0);
        append_insn(isa_pkg::ST, 0, 1, 5, 0);
        append_insn(isa_pkg::LD, 6, 1, 0, 0);
        append_insn(isa_pkg::ADD, 7, 6, 3, 0);
        append_insn(isa_pkg::SET_CONST, 0, 0, 0, 8'h41);
        append_insn(isa_pkg::ST, 0, 0, 7, 0);
        append_insn(isa_pkg::LD, 6, 0, 0, 0);
        append_insn(isa_pkg::LD, 5, 6, 0, 0);   // address straight from a load
        append_insn(isa_pkg::SET_CONST, 0, 0, 0, 8'h42);
        append_insn(isa_pkg::ST, 0, 0, 5, 0);
        append_insn(isa_pkg::READY, 0, 0, 0, 0);
        run_program(1'b0, '0, 2);

        // countdown loop summing 10..1
        program_q.delete();
        append_insn(isa_pkg::SET_CONST, 1, 0, 0, 10);
        append_insn(isa_pkg::SET_CONST, 2, 0, 0, 0);
        append_insn(isa_pkg::SET_CONST, 3, 0, 0, 1);
        append_insn(isa_pkg::SET_CONST, 4, 0, 0, 8'h50);
        append_insn(isa_pkg::ADD, 2, 2, 1, 0);
        append_insn(isa_pkg::SUB, 1, 1, 3, 0);
        append_insn(isa_pkg::BNZ, 0, 1, 0, 4);
        append_insn(isa_pkg::ADD, 2, 2, 3, 0);   // counted on every pass without a flush
        append_insn(isa_pkg::ADD, 2, 2, 3, 0);   // second slot behind the branch
        append_insn(isa_pkg::ST, 0, 4, 2, 0);
        append_insn(isa_pkg::READY, 0, 0, 0, 0);
        run_program(1'b0, '0, 3);

        // 32 store/load/store rounds under random wait states
        program_q.delete();
        append_insn(isa_pkg::SET_CONST, 1, 0, 0, 8'h80);
        append_insn(isa_pkg::SET_CONST, 2, 0, 0, 32);
        append_insn(isa_pkg::SET_CONST, 3, 0, 0, 1);
        append_insn(isa_pkg::SET_CONST, 4, 0, 0, 7);
        append_insn(isa_pkg::SET_CONST, 0, 0, 0, 8'h40);
        append_insn(isa_pkg::MUL, 5, 1, 4, 0);
        append_insn(isa_pkg::ST, 0, 1, 5, 0);
        append_insn(isa_pkg::LD, 6, 1, 0, 0);
        append_insn(isa_pkg::ADD, 6, 6, 3, 0);
        append_insn(isa_pkg::OR, 7, 1, 0, 0);
        append_insn(isa_pkg::ST, 0, 7, 6, 0);
        append_insn(isa_pkg::ADD, 1, 1, 3, 0);
        append_insn(isa_pkg::SUB, 2, 2, 3, 0);
        append_insn(isa_pkg::BNZ, 0, 2, 0, 5);
        append_insn(isa_pkg::READY, 0, 0, 0, 0);
        run_program(1'b0, '0, 4);

        build_random_program();
        preset_value = $random(seed);
        run_program(1'b1, preset_value, 5);

        $display("%0d of %0d tests checked, %0d errors", checked_count, NUM_TESTS, error_count);
        if (error_count == 0 && checked_count == NUM_TESTS)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: ready never returned within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

/* flist.f */
hdl/isa_pkg.sv
hdl/mem_pkg.sv
hdl/register_file.sv
hdl/insn_memory.sv
hdl/alu.sv
hdl/pipeline_core.sv
hdl/data_memory.sv
hdl/core_system.sv
dv/result_checker.sv
dv/core_system_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, then look for the pass line in the simulation output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module core_system_tb -f flist.f \
    && ./obj_dir/Vcore_system_tb | tee /dev/stderr | grep -x "Test passed" > /dev/null \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }
